//--- rv_ex_consts.svh
`ifndef RV_EX_CONSTS_SVH
`define RV_EX_CONSTS_SVH

// Datapath and register address widths
`define EX_XLEN        32
`define EX_REG_W       5

`define EX_LINK_OFFSET 4   // Return address is pc plus one instruction

`endif

//--- rv_ex_pkg.sv
`default_nettype none
`include "rv_ex_consts.svh"

package rv_ex_pkg;

    typedef enum logic [2:0] {
        CLS_MEM    = 3'd0,   // Zero so a cleared ID/EX is a harmless address calc
        CLS_BRANCH = 3'd1,
        CLS_ALU    = 3'd2,
        CLS_LUI    = 3'd3,
        CLS_AUIPC  = 3'd4,
        CLS_JAL    = 3'd5,
        CLS_JALR   = 3'd6
    } op_class_e;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } alu_fn_e;

    typedef enum logic [2:0] {
        BEQ  = 3'b000,       // Same as funct3
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } branch_op_e;

    typedef enum logic [1:0] {
        BR_NONE, BR_COND, BR_JUMP_PC, BR_JUMP_REG
    } br_kind_e;

    typedef enum logic [1:0] {
        SEL_RS, SEL_IMM, SEL_PC, SEL_CONST
    } opnd_sel_e;

    typedef struct packed {
        op_class_e             op_class;
        alu_fn_e               alu_fn;
        logic                  use_imm;
        branch_op_e            branch_op;
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
        logic [`EX_REG_W-1:0]  rd;
        logic [`EX_REG_W-1:0]  rs1;
        logic [`EX_REG_W-1:0]  rs2;
    } ex_ctrl_t;

    typedef struct packed {
        logic [`EX_XLEN-1:0] pc;
        logic [`EX_XLEN-1:0] rs1_value;
        logic [`EX_XLEN-1:0] rs2_value;
        logic [`EX_XLEN-1:0] imm;
    } ex_data_t;

    typedef struct packed {
        logic [`EX_XLEN-1:0]  result;
        logic [`EX_XLEN-1:0]  store_data;
        logic [`EX_REG_W-1:0] rd;
        logic                 reg_write;
        logic                 mem_read;
        logic                 mem_write;
    } mem_stage_t;

endpackage

`default_nettype wire

//--- ex_stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module ex_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t d,
    output payload_t q
);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            q <= '0;   // All fields clear, including control bits
        end
        else
        begin
            q <= d;    // Advances every cycle, no stall
        end
    end

endmodule

`default_nettype wire

//--- ex_forward_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_ex_consts.svh"

module ex_forward_unit (
    input  logic [`EX_REG_W-1:0] rs1,
    input  logic [`EX_REG_W-1:0] rs2,
    input  logic [`EX_XLEN-1:0]  rs1_value,
    input  logic [`EX_XLEN-1:0]  rs2_value,
    input  logic                 exm_reg_write,
    input  logic [`EX_REG_W-1:0] exm_rd,
    input  logic [`EX_XLEN-1:0]  exm_result,
    input  logic                 wb_reg_write,
    input  logic [`EX_REG_W-1:0] wb_rd,
    input  logic [`EX_XLEN-1:0]  wb_data,
    output logic [`EX_XLEN-1:0]  fwd_rs1,
    output logic [`EX_XLEN-1:0]  fwd_rs2
);

    logic exm_hit1;
    logic exm_hit2;
    logic wb_hit1;
    logic wb_hit2;

    // x0 is hardwired, so a write to it never forwards
    assign exm_hit1 = exm_reg_write && (exm_rd != '0) && (exm_rd == rs1);
    assign exm_hit2 = exm_reg_write && (exm_rd != '0) && (exm_rd == rs2);
    assign wb_hit1  = wb_reg_write && (wb_rd != '0) && (wb_rd == rs1);
    assign wb_hit2  = wb_reg_write && (wb_rd != '0) && (wb_rd == rs2);

    // Younger result in EX/MEM wins over MEM/WB
    assign fwd_rs1 = exm_hit1 ? exm_result : (wb_hit1 ? wb_data : rs1_value);
    assign fwd_rs2 = exm_hit2 ? exm_result : (wb_hit2 ? wb_data : rs2_value);

endmodule

`default_nettype wire

//--- ex_control.sv
`timescale 1ns/1ps
`default_nettype none

module ex_control (
    input  rv_ex_pkg::ex_ctrl_t  ctrl,
    output rv_ex_pkg::opnd_sel_e a_sel,
    output rv_ex_pkg::opnd_sel_e b_sel,
    output rv_ex_pkg::alu_fn_e   alu_fn,
    output rv_ex_pkg::br_kind_e  br_kind,
    output logic                 reg_write,
    output logic                 mem_read,
    output logic                 mem_write
);
    import rv_ex_pkg::*;

    always_comb
    begin
        a_sel     = SEL_RS;
        b_sel     = SEL_RS;
        alu_fn    = ADD;               // Address and link classes all add
        br_kind   = BR_NONE;
        reg_write = ctrl.reg_write;
        mem_read  = 1'b0;              // Only CLS_MEM touches memory
        mem_write = 1'b0;
        case (ctrl.op_class)
            CLS_MEM:
            begin
                b_sel     = SEL_IMM;   // rs1 + offset
                mem_read  = ctrl.mem_read;
                mem_write = ctrl.mem_write;
            end
            CLS_BRANCH:
            begin
                alu_fn  = SUB;         // Flags come from rs1 - rs2
                br_kind = BR_COND;
            end
            CLS_ALU:
            begin
                b_sel  = ctrl.use_imm ? SEL_IMM : SEL_RS;
                alu_fn = ctrl.alu_fn;
            end
            CLS_LUI:
            begin
                a_sel = SEL_CONST;     // 0 + imm
                b_sel = SEL_IMM;
            end
            CLS_AUIPC:
            begin
                a_sel = SEL_PC;
                b_sel = SEL_IMM;
            end
            CLS_JAL:
            begin
                a_sel   = SEL_PC;      // Link value pc + 4
                b_sel   = SEL_CONST;
                br_kind = BR_JUMP_PC;
            end
            CLS_JALR:
            begin
                a_sel   = SEL_PC;
                b_sel   = SEL_CONST;
                br_kind = BR_JUMP_REG;
            end
            default:
            begin
                reg_write = 1'b0;      // Unused class encoding does nothing
            end
        endcase
    end

endmodule

`default_nettype wire

//--- ex_operand_mux.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_ex_consts.svh"

module ex_operand_mux (
    input  rv_ex_pkg::opnd_sel_e a_sel,
    input  rv_ex_pkg::opnd_sel_e b_sel,
    input  logic [`EX_XLEN-1:0]  rs1,
    input  logic [`EX_XLEN-1:0]  rs2,
    input  logic [`EX_XLEN-1:0]  pc,
    input  logic [`EX_XLEN-1:0]  imm,
    output logic [`EX_XLEN-1:0]  alu_a,
    output logic [`EX_XLEN-1:0]  alu_b
);
    import rv_ex_pkg::*;

    always_comb
    begin
        case (a_sel)
            SEL_RS:    alu_a = rs1;
            SEL_IMM:   alu_a = imm;
            SEL_PC:    alu_a = pc;
            default:   alu_a = '0;                  // Constant zero for LUI
        endcase
    end

    always_comb
    begin
        case (b_sel)
            SEL_RS:    alu_b = rs2;
            SEL_IMM:   alu_b = imm;
            SEL_PC:    alu_b = pc;
            default:   alu_b = `EX_LINK_OFFSET;     // Link step for JAL and JALR
        endcase
    end

endmodule

`default_nettype wire

//--- ex_alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_ex_consts.svh"

module ex_alu (
    input  rv_ex_pkg::alu_fn_e  fn,
    input  logic [`EX_XLEN-1:0] a,
    input  logic [`EX_XLEN-1:0] b,
    output logic [`EX_XLEN-1:0] result,
    output logic                zero,
    output logic                lt,
    output logic                ltu
);
    import rv_ex_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];                      // RV32I uses five shift bits
    assign lt    = $signed(a) < $signed(b);     // No overflow trap, unlike sign of a - b
    assign ltu   = a < b;

    always_comb
    begin
        case (fn)
            ADD:     result = a + b;
            SUB:     result = a - b;
            SLL:     result = a << shamt;
            SLT:     result = {{(`EX_XLEN-1){1'b0}}, lt};
            SLTU:    result = {{(`EX_XLEN-1){1'b0}}, ltu};
            XOR:     result = a ^ b;
            SRL:     result = a >> shamt;
            SRA:     result = $signed(a) >>> shamt;
            OR:      result = a | b;
            AND:     result = a & b;
            default: result = '0;
        endcase
    end

    // Branch equality test, valid when fn is SUB
    assign zero = (result == '0);

endmodule

`default_nettype wire

//--- ex_branch_resolve.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_ex_consts.svh"

module ex_branch_resolve (
    input  rv_ex_pkg::br_kind_e   br_kind,
    input  rv_ex_pkg::branch_op_e branch_op,
    input  logic                  zero,
    input  logic                  lt,
    input  logic                  ltu,
    input  logic [`EX_XLEN-1:0]   pc,
    input  logic [`EX_XLEN-1:0]   rs1,
    input  logic [`EX_XLEN-1:0]   imm,
    output logic                  branch_taken,
    output logic [`EX_XLEN-1:0]   branch_target
);
    import rv_ex_pkg::*;

    logic cond_true;
    logic [`EX_XLEN-1:0] reg_target;

    always_comb
    begin
        case (branch_op)
            BEQ:     cond_true = zero;
            BNE:     cond_true = !zero;
            BLT:     cond_true = lt;
            BGE:     cond_true = !lt;
            BLTU:    cond_true = ltu;
            BGEU:    cond_true = !ltu;
            default: cond_true = 1'b0;          // Reserved funct3 never branches
        endcase
    end

    assign reg_target = rs1 + imm;

    always_comb
    begin
        case (br_kind)
            BR_COND:     branch_taken = cond_true;
            BR_JUMP_PC:  branch_taken = 1'b1;
            BR_JUMP_REG: branch_taken = 1'b1;
            default:     branch_taken = 1'b0;
        endcase
    end

    // JALR clears bit 0, others are pc relative
    assign branch_target = (br_kind == BR_JUMP_REG) ? {reg_target[`EX_XLEN-1:1], 1'b0}
                                                    : pc + imm;

endmodule

`default_nettype wire

//--- ex_stage_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_ex_consts.svh"

module ex_stage_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`EX_XLEN-1:0]     id_pc,
    input  logic [`EX_XLEN-1:0]     id_rs1_value,
    input  logic [`EX_XLEN-1:0]     id_rs2_value,
    input  logic [`EX_XLEN-1:0]     id_imm,
    input  logic [`EX_REG_W-1:0]    id_rs1,
    input  logic [`EX_REG_W-1:0]    id_rs2,
    input  logic [`EX_REG_W-1:0]    id_rd,
    input  rv_ex_pkg::op_class_e    id_op_class,
    input  rv_ex_pkg::alu_fn_e      id_alu_fn,
    input  logic                    id_use_imm,
    input  rv_ex_pkg::branch_op_e   id_branch_op,
    input  logic                    id_reg_write,
    input  logic                    id_mem_read,
    input  logic                    id_mem_write,
    input  logic                    wb_reg_write,
    input  logic [`EX_REG_W-1:0]    wb_rd,
    input  logic [`EX_XLEN-1:0]     wb_data,
    output logic [`EX_XLEN-1:0]     mem_result,
    output logic [`EX_XLEN-1:0]     mem_store_data,
    output logic [`EX_REG_W-1:0]    mem_rd,
    output logic                    mem_reg_write,
    output logic                    mem_mem_read,
    output logic                    mem_mem_write,
    output logic                    branch_taken,
    output logic [`EX_XLEN-1:0]     branch_target
);
    import rv_ex_pkg::*;

    ex_ctrl_t            id_ctrl_d;
    ex_data_t            id_data_d;
    ex_ctrl_t            id_ex_ctrl;
    ex_data_t            id_ex_data;
    mem_stage_t          ex_mem_d;
    mem_stage_t          ex_mem;
    opnd_sel_e           a_sel;
    opnd_sel_e           b_sel;
    alu_fn_e             alu_fn;
    br_kind_e            br_kind;
    logic                ctl_reg_write;
    logic                ctl_mem_read;
    logic                ctl_mem_write;
    logic [`EX_XLEN-1:0] fwd_rs1;
    logic [`EX_XLEN-1:0] fwd_rs2;
    logic [`EX_XLEN-1:0] alu_a;
    logic [`EX_XLEN-1:0] alu_b;
    logic [`EX_XLEN-1:0] alu_result;
    logic                zero;
    logic                lt;
    logic                ltu;

    always_comb
    begin
        id_ctrl_d.op_class  = id_op_class;
        id_ctrl_d.alu_fn    = id_alu_fn;
        id_ctrl_d.use_imm   = id_use_imm;
        id_ctrl_d.branch_op = id_branch_op;
        id_ctrl_d.reg_write = id_reg_write;
        id_ctrl_d.mem_read  = id_mem_read;
        id_ctrl_d.mem_write = id_mem_write;
        id_ctrl_d.rd        = id_rd;
        id_ctrl_d.rs1       = id_rs1;
        id_ctrl_d.rs2       = id_rs2;
        id_data_d.pc        = id_pc;
        id_data_d.rs1_value = id_rs1_value;
        id_data_d.rs2_value = id_rs2_value;
        id_data_d.imm       = id_imm;
    end

    ex_stage_reg #(.payload_t(ex_ctrl_t)) id_ex_ctrl_reg (
        .clk (clk),
        .rst (rst),
        .d   (id_ctrl_d),
        .q   (id_ex_ctrl)
    );

    ex_stage_reg #(.payload_t(ex_data_t)) id_ex_data_reg (
        .clk (clk),
        .rst (rst),
        .d   (id_data_d),
        .q   (id_ex_data)
    );

    ex_forward_unit u_forward (
        .rs1           (id_ex_ctrl.rs1),
        .rs2           (id_ex_ctrl.rs2),
        .rs1_value     (id_ex_data.rs1_value),
        .rs2_value     (id_ex_data.rs2_value),
        .exm_reg_write (ex_mem.reg_write),    // Own EX/MEM register is the newest source
        .exm_rd        (ex_mem.rd),
        .exm_result    (ex_mem.result),
        .wb_reg_write  (wb_reg_write),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data),
        .fwd_rs1       (fwd_rs1),
        .fwd_rs2       (fwd_rs2)
    );

    ex_control u_control (
        .ctrl      (id_ex_ctrl),
        .a_sel     (a_sel),
        .b_sel     (b_sel),
        .alu_fn    (alu_fn),
        .br_kind   (br_kind),
        .reg_write (ctl_reg_write),
        .mem_read  (ctl_mem_read),
        .mem_write (ctl_mem_write)
    );

    ex_operand_mux u_operand_mux (
        .a_sel (a_sel),
        .b_sel (b_sel),
        .rs1   (fwd_rs1),
        .rs2   (fwd_rs2),
        .pc    (id_ex_data.pc),
        .imm   (id_ex_data.imm),
        .alu_a (alu_a),
        .alu_b (alu_b)
    );

    ex_alu u_alu (
        .fn     (alu_fn),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .zero   (zero),
        .lt     (lt),
        .ltu    (ltu)
    );

    ex_branch_resolve u_branch (
        .br_kind       (br_kind),
        .branch_op     (id_ex_ctrl.branch_op),
        .zero          (zero),
        .lt            (lt),
        .ltu           (ltu),
        .pc            (id_ex_data.pc),
        .rs1           (fwd_rs1),
        .imm           (id_ex_data.imm),
        .branch_taken  (branch_taken),      // Combinational, resolved in EX
        .branch_target (branch_target)
    );

    always_comb
    begin
        ex_mem_d.result     = alu_result;
        ex_mem_d.store_data = fwd_rs2;         // Forwarded value, not the stale read
        ex_mem_d.rd         = id_ex_ctrl.rd;
        ex_mem_d.reg_write  = ctl_reg_write;
        ex_mem_d.mem_read   = ctl_mem_read;
        ex_mem_d.mem_write  = ctl_mem_write;
    end

    ex_stage_reg #(.payload_t(mem_stage_t)) ex_mem_reg (
        .clk (clk),
        .rst (rst),
        .d   (ex_mem_d),
        .q   (ex_mem)
    );

    assign mem_result     = ex_mem.result;
    assign mem_store_data = ex_mem.store_data;
    assign mem_rd         = ex_mem.rd;
    assign mem_reg_write  = ex_mem.reg_write;
    assign mem_mem_read   = ex_mem.mem_read;
    assign mem_mem_write  = ex_mem.mem_write;

endmodule

`default_nettype wire

//--- ex_checker.sv
`timescale 1ns/1ps
`default_nettype none

module ex_checker (
    input logic clk,
    input logic rst,
    input logic mem_reg_write,
    input logic mem_mem_read,
    input logic mem_mem_write,
    input logic branch_taken
);

    int fail_count = 0;

    reset_quiet: assert property (@(posedge clk)
        rst |-> (!mem_reg_write && !mem_mem_write && !branch_taken))
    else
    begin
        fail_count++;
        $error("write or branch output high during reset");
    end

    // A memory access is either a load or a store
    mem_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(mem_mem_read && mem_mem_write))
    else
    begin
        fail_count++;
        $error("mem_mem_read and mem_mem_write both high");
    end

    taken_known: assert property (@(posedge clk) disable iff (rst) !$isunknown(branch_taken))
    else
    begin
        fail_count++;
        $error("branch_taken is unknown");
    end

endmodule

bind ex_stage_top ex_checker u_checker (
    .clk           (clk),
    .rst           (rst),
    .mem_reg_write (mem_reg_write),
    .mem_mem_read  (mem_mem_read),
    .mem_mem_write (mem_mem_write),
    .branch_taken  (branch_taken)
);

`default_nettype wire

//--- ex_monitor.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_ex_consts.svh"

module ex_monitor (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`EX_XLEN-1:0]   id_pc,
    input  logic [`EX_XLEN-1:0]   id_rs1_value,
    input  logic [`EX_XLEN-1:0]   id_rs2_value,
    input  logic [`EX_XLEN-1:0]   id_imm,
    input  logic [`EX_REG_W-1:0]  id_rs1,
    input  logic [`EX_REG_W-1:0]  id_rs2,
    input  logic [`EX_REG_W-1:0]  id_rd,
    input  rv_ex_pkg::op_class_e  id_op_class,
    input  rv_ex_pkg::alu_fn_e    id_alu_fn,
    input  logic                  id_use_imm,
    input  rv_ex_pkg::branch_op_e id_branch_op,
    input  logic                  id_reg_write,
    input  logic                  id_mem_read,
    input  logic                  id_mem_write,
    input  logic                  wb_reg_write,
    input  logic [`EX_REG_W-1:0]  wb_rd,
    input  logic [`EX_XLEN-1:0]   wb_data,
    input  logic [`EX_XLEN-1:0]   mem_result,
    input  logic [`EX_XLEN-1:0]   mem_store_data,
    input  logic [`EX_REG_W-1:0]  mem_rd,
    input  logic                  mem_reg_write,
    input  logic                  mem_mem_read,
    input  logic                  mem_mem_write,
    input  logic                  branch_taken,
    input  logic [`EX_XLEN-1:0]   branch_target,
    output int                    error_count,
    output int                    check_count
);
    import rv_ex_pkg::*;

    ex_ctrl_t   cap_ctrl;     // Instruction held in ID/EX
    ex_data_t   cap_data;
    mem_stage_t exp_mem;      // Expected EX/MEM contents

    initial
    begin
        error_count = 0;
        check_count = 0;
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Newer EX/MEM result first, then MEM/WB, x0 never
    function automatic logic [31:0] forward(input logic [4:0] rs, input logic [31:0] value);
        if (exp_mem.reg_write && exp_mem.rd != 0 && exp_mem.rd == rs)
            return exp_mem.result;
        if (wb_reg_write && wb_rd != 0 && wb_rd == rs)
            return wb_data;
        return value;
    endfunction

    function automatic void ref_model(
        input  ex_ctrl_t    ctrl,
        input  logic [31:0] pc,
        input  logic [31:0] a,
        input  logic [31:0] b,
        input  logic [31:0] imm,
        output logic [31:0] res,
        output logic        taken,
        output logic [31:0] target
    );
        logic [31:0] y;
        y      = ctrl.use_imm ? imm : b;
        res    = a + imm;
        taken  = 1'b0;
        target = pc + imm;
        case (ctrl.op_class)
            CLS_BRANCH:
            begin
                res = a - b;
                case (ctrl.branch_op)
                    BEQ:     taken = (a == b);
                    BNE:     taken = (a != b);
                    BLT:     taken = ($signed(a) < $signed(b));
                    BGE:     taken = ($signed(a) >= $signed(b));
                    BLTU:    taken = (a < b);
                    default: taken = (a >= b);
                endcase
            end
            CLS_ALU:
            begin
                case (ctrl.alu_fn)
                    ADD:     res = a + y;
                    SUB:     res = a - y;
                    SLL:     res = a << y[4:0];
                    SLT:     res = ($signed(a) < $signed(y)) ? 32'd1 : 32'd0;
                    SLTU:    res = (a < y) ? 32'd1 : 32'd0;
                    XOR:     res = a ^ y;
                    SRL:     res = a >> y[4:0];
                    SRA:     res = $signed(a) >>> y[4:0];
                    OR:      res = a | y;
                    default: res = a & y;
                endcase
            end
            CLS_LUI:   res = imm;
            CLS_AUIPC: res = pc + imm;
            CLS_JAL:
            begin
                res   = pc + 32'd4;
                taken = 1'b1;
            end
            CLS_JALR:
            begin
                res    = pc + 32'd4;
                taken  = 1'b1;
                target = (a + imm) & ~32'd1;
            end
            default:   res = a + imm;   // Load or store address
        endcase
    endfunction

    always @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cap_ctrl <= '0;
            cap_data <= '0;
        end
        else
        begin
            cap_ctrl.op_class  <= id_op_class;
            cap_ctrl.alu_fn    <= id_alu_fn;
            cap_ctrl.use_imm   <= id_use_imm;
            cap_ctrl.branch_op <= id_branch_op;
            cap_ctrl.reg_write <= id_reg_write;
            cap_ctrl.mem_read  <= id_mem_read;
            cap_ctrl.mem_write <= id_mem_write;
            cap_ctrl.rd        <= id_rd;
            cap_ctrl.rs1       <= id_rs1;
            cap_ctrl.rs2       <= id_rs2;
            cap_data.pc        <= id_pc;
            cap_data.rs1_value <= id_rs1_value;
            cap_data.rs2_value <= id_rs2_value;
            cap_data.imm       <= id_imm;
        end
    end

    // Mid-cycle sampling, registers and wb inputs are settled
    always @(negedge clk)
    begin : compare
        logic [31:0] op1;
        logic [31:0] op2;
        logic [31:0] res;
        logic [31:0] tgt;
        logic        taken;
        logic        is_mem;
        if (rst)
        begin
            exp_mem = '0;
        end
        else
        begin
            check("mem_result", mem_result, exp_mem.result);
            check("mem_store_data", mem_store_data, exp_mem.store_data);
            check("mem_rd", 32'(mem_rd), 32'(exp_mem.rd));
            check("mem_reg_write", 32'(mem_reg_write), 32'(exp_mem.reg_write));
            check("mem_mem_read", 32'(mem_mem_read), 32'(exp_mem.mem_read));
            check("mem_mem_write", 32'(mem_mem_write), 32'(exp_mem.mem_write));
            op1 = forward(cap_ctrl.rs1, cap_data.rs1_value);
            op2 = forward(cap_ctrl.rs2, cap_data.rs2_value);
            ref_model(cap_ctrl, cap_data.pc, op1, op2, cap_data.imm, res, taken, tgt);
            check("branch_taken", 32'(branch_taken), 32'(taken));
            if (cap_ctrl.op_class == CLS_BRANCH || cap_ctrl.op_class == CLS_JAL ||
                cap_ctrl.op_class == CLS_JALR)
                check("branch_target", branch_target, tgt);
            is_mem             = (cap_ctrl.op_class == CLS_MEM);
            exp_mem.result     = res;
            exp_mem.store_data = op2;
            exp_mem.rd         = cap_ctrl.rd;
            exp_mem.reg_write  = cap_ctrl.reg_write;
            exp_mem.mem_read   = is_mem && cap_ctrl.mem_read;
            exp_mem.mem_write  = is_mem && cap_ctrl.mem_write;
        end
    end

endmodule

`default_nettype wire

//--- ex_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "rv_ex_consts.svh"

module ex_tb;
    import rv_ex_pkg::*;

    localparam int NUM_DIRECTED = 18;
    localparam int NUM_RANDOM   = 380;
    localparam int MAX_CYCLES   = NUM_DIRECTED + NUM_RANDOM + 20;   // Reset and drain fit in the margin

    logic                 clk;
    logic                 rst;
    logic [`EX_XLEN-1:0]  id_pc;
    logic [`EX_XLEN-1:0]  id_rs1_value;
    logic [`EX_XLEN-1:0]  id_rs2_value;
    logic [`EX_XLEN-1:0]  id_imm;
    logic [`EX_REG_W-1:0] id_rs1;
    logic [`EX_REG_W-1:0] id_rs2;
    logic [`EX_REG_W-1:0] id_rd;
    op_class_e            id_op_class;
    alu_fn_e              id_alu_fn;
    logic                 id_use_imm;
    branch_op_e           id_branch_op;
    logic                 id_reg_write;
    logic                 id_mem_read;
    logic                 id_mem_write;
    logic                 wb_reg_write;
    logic [`EX_REG_W-1:0] wb_rd;
    logic [`EX_XLEN-1:0]  wb_data;
    logic [`EX_XLEN-1:0]  mem_result;
    logic [`EX_XLEN-1:0]  mem_store_data;
    logic [`EX_REG_W-1:0] mem_rd;
    logic                 mem_reg_write;
    logic                 mem_mem_read;
    logic                 mem_mem_write;
    logic                 branch_taken;
    logic [`EX_XLEN-1:0]  branch_target;
    int                   error_count;
    int                   check_count;
    int                   cycle_count;
    int                   total_errors;
    logic [31:0]          lfsr;
    logic                 wb_on;        // Write-back side stays idle in the directed part

    ex_stage_top UUT (.*);

    ex_monitor monitor (.*);

    always #10 clk = ~clk;

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] val;
        int          i;
        val = '0;
        for (i = 0; i < n; i++)
        begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return val;
    endfunction

    task automatic issue(
        input op_class_e   cls,
        input alu_fn_e     fn,
        input int          use_imm,
        input branch_op_e  bop,
        input int          rd,
        input int          rs1,
        input int          rs2,
        input logic [31:0] v1,
        input logic [31:0] v2,
        input logic [31:0] imm,
        input int          regw,
        input int          mr,
        input int          mw
    );
        @(posedge clk);
        id_op_class  <= cls;
        id_alu_fn    <= fn;
        id_use_imm   <= 1'(use_imm);
        id_branch_op <= bop;
        id_rd        <= 5'(rd);
        id_rs1       <= 5'(rs1);
        id_rs2       <= 5'(rs2);
        id_rs1_value <= v1;
        id_rs2_value <= v2;
        id_imm       <= imm;
        id_reg_write <= 1'(regw);
        id_mem_read  <= 1'(mr);
        id_mem_write <= 1'(mw);
        id_pc        <= take_bits(32) & 32'hFFFF_FFFC;   // Word aligned
        if (wb_on)
        begin
            wb_reg_write <= 1'(take_bits(1));
            wb_rd        <= 5'(take_bits(2));
            wb_data      <= take_bits(32);
        end
    endtask

    task automatic issue_random();
        op_class_e   cls;
        alu_fn_e     fn;
        branch_op_e  bop;
        logic [31:0] v1;
        logic [31:0] v2;
        logic [31:0] imm;
        int          k;
        int          mr;
        int          mw;
        int          use_imm;
        int          rd;
        int          rs1;
        int          rs2;
        int          regw;
        cls     = op_class_e'(take_bits(3) % 7);
        fn      = alu_fn_e'(take_bits(4) % 10);
        k       = int'(take_bits(3) % 6);
        bop     = branch_op_e'((k < 2) ? k : k + 2);     // Skip the reserved funct3 codes
        v1      = take_bits(32);
        v2      = (take_bits(2) == 0) ? v1 : take_bits(32);
        imm     = take_bits(32);
        mr      = int'(take_bits(1));
        mw      = (mr == 0) ? int'(take_bits(1)) : 0;   // Read and write are exclusive
        use_imm = int'(take_bits(1));
        rd      = int'(take_bits(2));                   // x0..x3 so forwarding hits often
        rs1     = int'(take_bits(2));
        rs2     = int'(take_bits(2));
        regw    = int'(take_bits(1));
        issue(cls, fn, use_imm, bop, rd, rs1, rs2, v1, v2, imm, regw, mr, mw);
    endtask

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("timeout: test did not finish");
            $display(">>> FAIL");
            $finish;
        end
    end

    initial
    begin
        clk          = 1'b0;
        rst          = 1'b1;
        id_pc        = '0;
        id_rs1_value = '0;
        id_rs2_value = '0;
        id_imm       = '0;
        id_rs1       = '0;
        id_rs2       = '0;
        id_rd        = '0;
        id_op_class  = CLS_MEM;
        id_alu_fn    = ADD;
        id_use_imm   = 1'b0;
        id_branch_op = BEQ;
        id_reg_write = 1'b0;
        id_mem_read  = 1'b0;
        id_mem_write = 1'b0;
        wb_reg_write = 1'b0;
        wb_rd        = '0;
        wb_data      = '0;
        cycle_count  = 0;
        lfsr         = 32'd10728;
        wb_on        = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        issue(CLS_ALU, ADD, 1, BEQ, 1, 0, 0, 0, 0, 'h10, 1, 0, 0);
        issue(CLS_ALU, SUB, 0, BEQ, 2, 1, 1, 'h5, 'h7, 0, 1, 0, 0);   // Both from EX/MEM
        issue(CLS_ALU, XOR, 1, BEQ, 0, 1, 0, 'h3, 0, 'hFFFF, 1, 0, 0); // Write to x0
        issue(CLS_ALU, ADD, 0, BEQ, 3, 0, 0, 0, 0, 0, 1, 0, 0);        // Reads x0 after it
        issue(CLS_BRANCH, ADD, 0, BEQ, 0, 1, 2, 'h5, 'h5, 'h40, 0, 0, 0);
        issue(CLS_BRANCH, ADD, 0, BNE, 0, 1, 2, 'h5, 'h6, 'h44, 0, 0, 0);
        issue(CLS_BRANCH, ADD, 0, BLT, 0, 1, 2, 'h7FFF_FFFF, 'h8000_0000, 'h48, 0, 0, 0);
        issue(CLS_BRANCH, ADD, 0, BGE, 0, 1, 2, 'h7FFF_FFFF, 'h8000_0000, 'h4C, 0, 0, 0);
        issue(CLS_BRANCH, ADD, 0, BLT, 0, 1, 2, 'h8000_0000, 'h1, 'h50, 0, 0, 0);
        issue(CLS_BRANCH, ADD, 0, BLTU, 0, 1, 2, 'h1, 'hFFFF_FFFF, 'h54, 0, 0, 0);
        issue(CLS_BRANCH, ADD, 0, BGEU, 0, 1, 2, 'h1, 'hFFFF_FFFF, 'h58, 0, 0, 0);
        issue(CLS_JAL, ADD, 0, BEQ, 1, 0, 0, 0, 0, 'h100, 1, 0, 0);
        issue(CLS_JALR, ADD, 0, BEQ, 2, 1, 0, 'h9, 0, 'h7, 1, 0, 0);   // rs1 is the link value
        issue(CLS_LUI, ADD, 0, BEQ, 3, 0, 0, 0, 0, 'hABCD_E000, 1, 0, 0);
        issue(CLS_AUIPC, ADD, 0, BEQ, 1, 0, 0, 0, 0, 'h1000, 1, 0, 0);
        issue(CLS_MEM, ADD, 0, BEQ, 2, 1, 0, 'h20, 0, 'h8, 1, 1, 0);  // Load
        issue(CLS_MEM, ADD, 0, BEQ, 0, 3, 2, 'h30, 'h44, 'hC, 0, 0, 1);
        issue(CLS_ALU, SRA, 1, BEQ, 1, 2, 0, 'h8000_00F0, 0, 'h24, 1, 0, 0);
        wb_on = 1'b1;
        repeat (NUM_RANDOM) issue_random();
        repeat (3) @(posedge clk);
        @(negedge clk);
        #1;
        total_errors = error_count + UUT.u_checker.fail_count;
        $display("checks %0d, value errors %0d, assertion failures %0d",
                 check_count, error_count, UUT.u_checker.fail_count);
        if (total_errors == 0)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
rv_ex_pkg.sv
ex_stage_reg.sv
ex_forward_unit.sv
ex_control.sv
ex_operand_mux.sv
ex_alu.sv
ex_branch_resolve.sv
ex_stage_top.sv
ex_checker.sv
ex_monitor.sv
ex_tb.sv

//--- Bender.yml
package:
  name: rv_ex_stage

sources:
  - include_dirs:
      - .
    files:
      - rv_ex_pkg.sv
      - ex_stage_reg.sv
      - ex_forward_unit.sv
      - ex_control.sv
      - ex_operand_mux.sv
      - ex_alu.sv
      - ex_branch_resolve.sv
      - ex_stage_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - ex_checker.sv
      - ex_monitor.sv
      - ex_tb.sv
